// File: src/rvDecodePkg.sv
package rvDecodePkg;

    localparam int XLEN      = 32;
    localparam int AddrWidth = 4;

    // Major opcodes
    localparam logic [6:0] OpLui    = 7'b0110111;
    localparam logic [6:0] OpAuipc  = 7'b0010111;
    localparam logic [6:0] OpJal    = 7'b1101111;
    localparam logic [6:0] OpJalr   = 7'b1100111;
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpLoad   = 7'b0000011;
    localparam logic [6:0] OpStore  = 7'b0100011;
    localparam logic [6:0] OpAlu    = 7'b0110011;
    localparam logic [6:0] OpAluImm = 7'b0010011;

    localparam logic [2:0] F3Beq   = 3'b000;
    localparam logic [2:0] F3Bne   = 3'b001;
    localparam logic [2:0] F3Blt   = 3'b100;
    localparam logic [2:0] F3Bge   = 3'b101;
    localparam logic [2:0] F3Bltu  = 3'b110;
    localparam logic [2:0] F3Bgeu  = 3'b111;
    localparam logic [2:0] F3Byte  = 3'b000;   // Loads and stores
    localparam logic [2:0] F3Half  = 3'b001;
    localparam logic [2:0] F3Word  = 3'b010;
    localparam logic [2:0] F3ByteU = 3'b100;
    localparam logic [2:0] F3HalfU = 3'b101;

    localparam logic [6:0] F7Base = 7'b0000000;
    localparam logic [6:0] F7Alt  = 7'b0100000;  // SUB, SRA, SRAI

    // ALU ops follow funct3 of the ALU forms
    localparam logic [2:0] AluAdd  = 3'b000;
    localparam logic [2:0] AluSll  = 3'b001;
    localparam logic [2:0] AluSlt  = 3'b010;
    localparam logic [2:0] AluSltu = 3'b011;
    localparam logic [2:0] AluXor  = 3'b100;
    localparam logic [2:0] AluShr  = 3'b101;
    localparam logic [2:0] AluOr   = 3'b110;
    localparam logic [2:0] AluAnd  = 3'b111;

    localparam logic [1:0] MemByte = 2'b00;
    localparam logic [1:0] MemHalf = 2'b01;
    localparam logic [1:0] MemWord = 2'b10;

    // Control word bit positions
    localparam int CtrlAluOpLsb   = 0;
    localparam int CtrlNegate     = 3;
    localparam int CtrlRegWrite   = 4;
    localparam int CtrlBSrc       = 5;
    localparam int CtrlMemSigned  = 6;
    localparam int CtrlMemWrite   = 7;
    localparam int CtrlMemRead    = 8;
    localparam int CtrlMemSizeLsb = 9;
    localparam int CtrlBeq        = 11;
    localparam int CtrlBne        = 12;
    localparam int CtrlBlt        = 13;
    localparam int CtrlBge        = 14;
    localparam int CtrlBltu       = 15;
    localparam int CtrlBgeu       = 16;
    localparam int CtrlLui        = 17;
    localparam int CtrlAuipc      = 18;
    localparam int CtrlJal        = 19;
    localparam int CtrlJalr       = 20;
    localparam int CtrlValid      = 21;
    localparam int CtrlWidth      = 23;  // Bit 22 spare, reads zero

    localparam logic [AddrWidth-1:0] AddrInstr = 4'h0;
    localparam logic [AddrWidth-1:0] AddrCtrl  = 4'h4;
    localparam logic [AddrWidth-1:0] AddrImm   = 4'h8;

endpackage

// File: src/opDecoder.sv
`timescale 1ns/1ps

module opDecoder
(
    input  logic [rvDecodePkg::XLEN-1:0]      instr,
    output logic [rvDecodePkg::CtrlWidth-1:0] ctrlWord
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [1:0] memSize;
    logic       isShift;
    logic       isCmp;
    logic       alt;
    logic       altOk;
    logic       known;
    logic [rvDecodePkg::CtrlWidth-1:0] ctrl;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign isShift = (funct3 == rvDecodePkg::AluSll) || (funct3 == rvDecodePkg::AluShr);
    assign isCmp   = (funct3 == rvDecodePkg::AluSlt) || (funct3 == rvDecodePkg::AluSltu);
    assign alt     = (funct7 == rvDecodePkg::F7Alt);

    assign memSize = (funct3[1:0] == 2'b10) ? rvDecodePkg::MemWord :
                     funct3[0]              ? rvDecodePkg::MemHalf : rvDecodePkg::MemByte;

    // Only SUB and SRA/SRAI accept the alternate funct7
    always_comb
    begin
        altOk = 1'b0;
        if (funct7 == rvDecodePkg::F7Base)
            altOk = 1'b1;
        else if (alt)
            altOk = (funct3 == rvDecodePkg::AluAdd) || (funct3 == rvDecodePkg::AluShr);
    end

    always_comb
    begin
        ctrl  = '0;
        known = 1'b0;
        case (opcode)
            rvDecodePkg::OpLui,
            rvDecodePkg::OpAuipc,
            rvDecodePkg::OpJal:
            begin
                known = 1'b1;
                ctrl[rvDecodePkg::CtrlRegWrite] = 1'b1;
                ctrl[rvDecodePkg::CtrlBSrc]     = 1'b1;
                ctrl[rvDecodePkg::CtrlLui]      = (opcode == rvDecodePkg::OpLui);
                ctrl[rvDecodePkg::CtrlAuipc]    = (opcode == rvDecodePkg::OpAuipc);
                ctrl[rvDecodePkg::CtrlJal]      = (opcode == rvDecodePkg::OpJal);
            end
            rvDecodePkg::OpJalr:
            begin
                known = (funct3 == 3'b000);
                ctrl[rvDecodePkg::CtrlRegWrite] = 1'b1;
                ctrl[rvDecodePkg::CtrlBSrc]     = 1'b1;
                ctrl[rvDecodePkg::CtrlJalr]     = 1'b1;
            end
            rvDecodePkg::OpBranch:
            begin
                known = (funct3 != 3'b010) && (funct3 != 3'b011);
                ctrl[rvDecodePkg::CtrlNegate] = 1'b1;   // Compare by subtraction
                ctrl[rvDecodePkg::CtrlBeq]    = (funct3 == rvDecodePkg::F3Beq);
                ctrl[rvDecodePkg::CtrlBne]    = (funct3 == rvDecodePkg::F3Bne);
                ctrl[rvDecodePkg::CtrlBlt]    = (funct3 == rvDecodePkg::F3Blt);
                ctrl[rvDecodePkg::CtrlBge]    = (funct3 == rvDecodePkg::F3Bge);
                ctrl[rvDecodePkg::CtrlBltu]   = (funct3 == rvDecodePkg::F3Bltu);
                ctrl[rvDecodePkg::CtrlBgeu]   = (funct3 == rvDecodePkg::F3Bgeu);
            end
            rvDecodePkg::OpLoad:
            begin
                known = (funct3 == rvDecodePkg::F3Byte) || (funct3 == rvDecodePkg::F3Half) ||
                        (funct3 == rvDecodePkg::F3Word) || (funct3 == rvDecodePkg::F3ByteU) ||
                        (funct3 == rvDecodePkg::F3HalfU);
                ctrl[rvDecodePkg::CtrlRegWrite]  = 1'b1;
                ctrl[rvDecodePkg::CtrlBSrc]      = 1'b1;
                ctrl[rvDecodePkg::CtrlMemRead]   = 1'b1;
                ctrl[rvDecodePkg::CtrlMemSigned] = (funct3 != rvDecodePkg::F3ByteU) &&
                                                   (funct3 != rvDecodePkg::F3HalfU);
                ctrl[rvDecodePkg::CtrlMemSizeLsb +: 2] = memSize;
            end
            rvDecodePkg::OpStore:
            begin
                known = (funct3 == rvDecodePkg::F3Byte) || (funct3 == rvDecodePkg::F3Half) ||
                        (funct3 == rvDecodePkg::F3Word);
                ctrl[rvDecodePkg::CtrlBSrc]            = 1'b1;
                ctrl[rvDecodePkg::CtrlMemWrite]        = 1'b1;
                ctrl[rvDecodePkg::CtrlMemSizeLsb +: 2] = memSize;
            end
            rvDecodePkg::OpAlu:
            begin
                known = altOk;
                ctrl[rvDecodePkg::CtrlRegWrite]      = 1'b1;
                ctrl[rvDecodePkg::CtrlAluOpLsb +: 3] = funct3;
                ctrl[rvDecodePkg::CtrlNegate]        = isCmp || alt;  // SUB, SRA, SLT, SLTU
            end
            rvDecodePkg::OpAluImm:
            begin
                known = !isShift || altOk;     // funct7 only matters for shifts
                ctrl[rvDecodePkg::CtrlRegWrite]      = 1'b1;
                ctrl[rvDecodePkg::CtrlBSrc]          = 1'b1;
                ctrl[rvDecodePkg::CtrlAluOpLsb +: 3] = funct3;
                ctrl[rvDecodePkg::CtrlNegate]        = isCmp || (isShift && alt);
            end
            default:
            begin
                known = 1'b0;
            end
        endcase
        ctrl[rvDecodePkg::CtrlValid] = known;
    end

    assign ctrlWord = known ? ctrl : '0;   // Invalid reads as NOP

endmodule

// File: src/immGen.sv
`timescale 1ns/1ps

module immGen
(
    input  logic [rvDecodePkg::XLEN-1:0] instr,
    output logic [rvDecodePkg::XLEN-1:0] immediate
);

    typedef enum logic [2:0] {FmtNone, FmtU, FmtB, FmtI, FmtIu, FmtS, FmtShamt} fmtT;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    fmtT        fmt;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb
    begin
        fmt = FmtNone;   // Jumps and register forms
        case (opcode)
            rvDecodePkg::OpLui,
            rvDecodePkg::OpAuipc:
                fmt = FmtU;
            rvDecodePkg::OpBranch:
                if ((funct3 != 3'b010) && (funct3 != 3'b011))
                    fmt = FmtB;
            rvDecodePkg::OpLoad:
                if ((funct3 != 3'b011) && (funct3[2:1] != 2'b11))
                    fmt = FmtI;
            rvDecodePkg::OpStore:
                if (!funct3[2] && (funct3 != 3'b011))
                    fmt = FmtS;
            rvDecodePkg::OpAluImm:
                case (funct3)
                    rvDecodePkg::AluSltu:
                        fmt = FmtIu;
                    rvDecodePkg::AluSll:
                        if (funct7 == rvDecodePkg::F7Base)
                            fmt = FmtShamt;
                    rvDecodePkg::AluShr:
                        if ((funct7 == rvDecodePkg::F7Base) || (funct7 == rvDecodePkg::F7Alt))
                            fmt = FmtShamt;
                    default:
                        fmt = FmtI;
                endcase
            default:
                fmt = FmtNone;
        endcase
    end

    always_comb
    begin
        case (fmt)
            FmtU:     immediate = {{(rvDecodePkg::XLEN-20){instr[31]}}, instr[31:12]};  // Unshifted
            FmtB:     immediate = {{(rvDecodePkg::XLEN-12){instr[31]}}, instr[7], instr[30:25],
                                   instr[11:8], 1'b0};
            FmtI:     immediate = {{(rvDecodePkg::XLEN-12){instr[31]}}, instr[31:20]};
            FmtIu:    immediate = {{(rvDecodePkg::XLEN-12){1'b0}}, instr[31:20]};
            FmtS:     immediate = {{(rvDecodePkg::XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            FmtShamt: immediate = {{(rvDecodePkg::XLEN-5){1'b0}}, instr[24:20]};
            default:  immediate = '0;
        endcase
    end

endmodule

// File: src/apbRegBlock.sv
`timescale 1ns/1ps

module apbRegBlock
(
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [rvDecodePkg::AddrWidth-1:0]    paddr,
    input  logic [rvDecodePkg::XLEN-1:0]         pwdata,
    input  logic [rvDecodePkg::CtrlWidth-1:0]    ctrlWord,
    input  logic [rvDecodePkg::XLEN-1:0]         immediate,
    output logic [rvDecodePkg::XLEN-1:0]         instr,
    output logic [rvDecodePkg::XLEN-1:0]         prdata,
    output logic                                 pready,
    output logic                                 pslverr
);

    logic [rvDecodePkg::CtrlWidth-1:0] ctrlReg;
    logic [rvDecodePkg::XLEN-1:0]      immReg;
    logic                              stale;

    logic access;
    logic selInstr;
    logic selCtrl;
    logic selImm;
    logic badAccess;
    logic waitStale;
    logic wrInstr;

    assign access   = psel && penable;
    assign selInstr = (paddr == rvDecodePkg::AddrInstr);
    assign selCtrl  = (paddr == rvDecodePkg::AddrCtrl);
    assign selImm   = (paddr == rvDecodePkg::AddrImm);

    // Unmapped address or write to a result register
    assign badAccess = !(selInstr || selCtrl || selImm) || (pwrite && !selInstr);

    // Results lag the instruction register by one edge
    assign waitStale = !pwrite && (selCtrl || selImm) && stale;

    assign pready  = access && !waitStale;
    assign pslverr = access && badAccess;
    assign wrInstr = access && pwrite && selInstr;

    always_comb
    begin
        prdata = '0;
        if (pready && !pwrite)
        begin
            if (selInstr)
                prdata = instr;
            else if (selCtrl)
                prdata = {{(rvDecodePkg::XLEN-rvDecodePkg::CtrlWidth){1'b0}}, ctrlReg};
            else if (selImm)
                prdata = immReg;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            instr   <= '0;
            ctrlReg <= '0;
            immReg  <= '0;
            stale   <= 1'b0;   // Zero word decodes to zero results
        end
        else if (wrInstr)
        begin
            instr <= pwdata;
            stale <= 1'b1;
        end
        else if (stale)
        begin
            ctrlReg <= ctrlWord;   // Capture decode of new word
            immReg  <= immediate;
            stale   <= 1'b0;
        end
    end

endmodule

// File: src/rvDecodeApb.sv
`timescale 1ns/1ps

module rvDecodeApb
(
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [rvDecodePkg::AddrWidth-1:0] paddr,
    input  logic [rvDecodePkg::XLEN-1:0]      pwdata,
    output logic [rvDecodePkg::XLEN-1:0]      prdata,
    output logic                              pready,
    output logic                              pslverr
);

    logic [rvDecodePkg::XLEN-1:0]      instr;
    logic [rvDecodePkg::CtrlWidth-1:0] ctrlWord;
    logic [rvDecodePkg::XLEN-1:0]      immediate;

    apbRegBlock regs
    (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .ctrlWord  (ctrlWord),
        .immediate (immediate),
        .instr     (instr),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr)
    );

    opDecoder dec
    (
        .instr    (instr),
        .ctrlWord (ctrlWord)
    );

    immGen imm
    (
        .instr     (instr),
        .immediate (immediate)
    );

endmodule

// File: dv/decodeApb_checker.sv
`timescale 1ns/1ps

module decodeApb_checker
(
    input logic                              clk,
    input logic                              rst,
    input logic                              psel,
    input logic                              penable,
    input logic [rvDecodePkg::AddrWidth-1:0] paddr,
    input logic                              pready,
    input logic                              pslverr
);

    int assertFails = 0;

    idleQuiet: assert property (@(posedge clk) disable iff (rst)
        !(psel && penable) |-> !pready && !pslverr)
    else
    begin
        assertFails++;
        $error("pready or pslverr high outside an access phase");
    end

    addrHeld: assert property (@(posedge clk) disable iff (rst)
        (psel && penable && !pready) |=> $stable(paddr))
    else
    begin
        assertFails++;
        $error("paddr changed while the access phase was waiting");
    end

    // Stale results cost at most one wait
    singleWait: assert property (@(posedge clk) disable iff (rst)
        (psel && penable && !pready) |=> pready)
    else
    begin
        assertFails++;
        $error("access phase waited more than one cycle");
    end

endmodule

bind rvDecodeApb decodeApb_checker apbChk
(
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .paddr   (paddr),
    .pready  (pready),
    .pslverr (pslverr)
);

// File: dv/decodeMonitor.sv
`timescale 1ns/1ps

module decodeMonitor
(
    input logic                              clk,
    input logic                              rst,
    input logic                              psel,
    input logic                              penable,
    input logic                              pwrite,
    input logic [rvDecodePkg::AddrWidth-1:0] paddr,
    input logic [rvDecodePkg::XLEN-1:0]      pwdata,
    input logic [rvDecodePkg::XLEN-1:0]      prdata,
    input logic                              pready,
    input logic                              pslverr
);

    string                        testName   = "none";
    int                           errorCount = 0;
    int                           waitCycles = 0;
    logic [rvDecodePkg::XLEN-1:0] lastInstr  = '0;

    function automatic logic [1:0] memSizeOf(input logic [2:0] f3);
        case (f3)
            rvDecodePkg::F3Half, rvDecodePkg::F3HalfU: return rvDecodePkg::MemHalf;
            rvDecodePkg::F3Word:                       return rvDecodePkg::MemWord;
            default:                                   return rvDecodePkg::MemByte;
        endcase
    endfunction

    // Returns {immediate, control word}
    function automatic logic [rvDecodePkg::XLEN+rvDecodePkg::CtrlWidth-1:0] refDecode
        (input logic [rvDecodePkg::XLEN-1:0] ins);
        logic [6:0]                        op;
        logic [2:0]                        f3;
        logic [6:0]                        f7;
        logic                              ok;
        logic [rvDecodePkg::CtrlWidth-1:0] c;
        logic [rvDecodePkg::XLEN-1:0]      im;
        logic [rvDecodePkg::XLEN-1:0]      immI;
        op   = ins[6:0];
        f3   = ins[14:12];
        f7   = ins[31:25];
        immI = {{20{ins[31]}}, ins[31:20]};
        c    = '0;
        im   = '0;
        ok   = 1'b1;
        case (op)
            rvDecodePkg::OpLui:
            begin
                c[rvDecodePkg::CtrlLui] = 1'b1;
                im = {{12{ins[31]}}, ins[31:12]};   // Not shifted
            end
            rvDecodePkg::OpAuipc:
            begin
                c[rvDecodePkg::CtrlAuipc] = 1'b1;
                im = {{12{ins[31]}}, ins[31:12]};
            end
            rvDecodePkg::OpJal:
                c[rvDecodePkg::CtrlJal] = 1'b1;
            rvDecodePkg::OpJalr:
            begin
                c[rvDecodePkg::CtrlJalr] = 1'b1;
                ok = (f3 == 3'b000);
            end
            rvDecodePkg::OpBranch:
            begin
                c[rvDecodePkg::CtrlNegate] = 1'b1;
                im = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                case (f3)
                    rvDecodePkg::F3Beq:  c[rvDecodePkg::CtrlBeq]  = 1'b1;
                    rvDecodePkg::F3Bne:  c[rvDecodePkg::CtrlBne]  = 1'b1;
                    rvDecodePkg::F3Blt:  c[rvDecodePkg::CtrlBlt]  = 1'b1;
                    rvDecodePkg::F3Bge:  c[rvDecodePkg::CtrlBge]  = 1'b1;
                    rvDecodePkg::F3Bltu: c[rvDecodePkg::CtrlBltu] = 1'b1;
                    rvDecodePkg::F3Bgeu: c[rvDecodePkg::CtrlBgeu] = 1'b1;
                    default:             ok = 1'b0;
                endcase
            end
            rvDecodePkg::OpLoad:
            begin
                ok = (f3 == rvDecodePkg::F3Byte) || (f3 == rvDecodePkg::F3Half) ||
                     (f3 == rvDecodePkg::F3Word) || (f3 == rvDecodePkg::F3ByteU) ||
                     (f3 == rvDecodePkg::F3HalfU);
                c[rvDecodePkg::CtrlMemRead]          = 1'b1;
                c[rvDecodePkg::CtrlMemSigned]        = (f3 != rvDecodePkg::F3ByteU) &&
                                                       (f3 != rvDecodePkg::F3HalfU);
                c[rvDecodePkg::CtrlMemSizeLsb +: 2] = memSizeOf(f3);
                im = immI;
            end
            rvDecodePkg::OpStore:
            begin
                ok = (f3 == rvDecodePkg::F3Byte) || (f3 == rvDecodePkg::F3Half) ||
                     (f3 == rvDecodePkg::F3Word);
                c[rvDecodePkg::CtrlMemWrite]         = 1'b1;
                c[rvDecodePkg::CtrlMemSizeLsb +: 2] = memSizeOf(f3);
                im = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            end
            rvDecodePkg::OpAlu:
            begin
                ok = (f7 == rvDecodePkg::F7Base) || ((f7 == rvDecodePkg::F7Alt) &&
                     ((f3 == rvDecodePkg::AluAdd) || (f3 == rvDecodePkg::AluShr)));
                c[rvDecodePkg::CtrlAluOpLsb +: 3] = f3;
                c[rvDecodePkg::CtrlNegate] = (f7 == rvDecodePkg::F7Alt) ||
                    (f3 == rvDecodePkg::AluSlt) || (f3 == rvDecodePkg::AluSltu);
            end
            rvDecodePkg::OpAluImm:
            begin
                c[rvDecodePkg::CtrlAluOpLsb +: 3] = f3;
                c[rvDecodePkg::CtrlNegate] = (f3 == rvDecodePkg::AluSlt) ||
                                             (f3 == rvDecodePkg::AluSltu);
                im = immI;
                if (f3 == rvDecodePkg::AluSltu)
                    im = {20'b0, ins[31:20]};
                else if ((f3 == rvDecodePkg::AluSll) || (f3 == rvDecodePkg::AluShr))
                begin
                    im = {27'b0, ins[24:20]};   // Shift amount
                    ok = (f7 == rvDecodePkg::F7Base) ||
                         ((f3 == rvDecodePkg::AluShr) && (f7 == rvDecodePkg::F7Alt));
                    c[rvDecodePkg::CtrlNegate] = (f7 == rvDecodePkg::F7Alt);
                end
            end
            default:
                ok = 1'b0;
        endcase
        c[rvDecodePkg::CtrlRegWrite] = (op != rvDecodePkg::OpBranch) && (op != rvDecodePkg::OpStore);
        c[rvDecodePkg::CtrlBSrc]     = (op != rvDecodePkg::OpBranch) && (op != rvDecodePkg::OpAlu);
        c[rvDecodePkg::CtrlValid]    = 1'b1;
        if (!ok)
        begin
            c  = '0;
            im = '0;
        end
        return {im, c};
    endfunction

    task automatic compareValue(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (expected !== actual)
        begin
            errorCount++;
            $display("** Error %s %s: expected %h, actual %h", testName, what, expected, actual);
        end
    endtask

    task automatic checkTransfer();
        logic [rvDecodePkg::XLEN+rvDecodePkg::CtrlWidth-1:0] expDec;
        logic                                                expErr;
        logic [rvDecodePkg::XLEN-1:0]                        expData;
        expDec  = refDecode(lastInstr);
        expErr  = !((paddr == rvDecodePkg::AddrInstr) || (paddr == rvDecodePkg::AddrCtrl) ||
                    (paddr == rvDecodePkg::AddrImm)) ||
                  (pwrite && (paddr != rvDecodePkg::AddrInstr));
        expData = '0;
        if (!expErr && !pwrite)
        begin
            if (paddr == rvDecodePkg::AddrInstr)
                expData = lastInstr;
            else if (paddr == rvDecodePkg::AddrCtrl)
                expData = {{(rvDecodePkg::XLEN-rvDecodePkg::CtrlWidth){1'b0}},
                           expDec[rvDecodePkg::CtrlWidth-1:0]};
            else
                expData = expDec[rvDecodePkg::XLEN+rvDecodePkg::CtrlWidth-1:rvDecodePkg::CtrlWidth];
        end
        if (waitCycles > 1)
        begin
            errorCount++;
            $display("%s: access to %h waited %0d cycles, more than one", testName, paddr,
                     waitCycles);
        end
        compareValue($sformatf("pslverr@%h", paddr), {31'b0, expErr}, {31'b0, pslverr});
        if (!pwrite || expErr)
            compareValue($sformatf("prdata@%h", paddr), expData, prdata);
        if (pwrite && !expErr)
            lastInstr = pwdata;
        waitCycles = 0;
    endtask

    // Sampled mid-cycle, the transfer completes on the next rising edge
    always @(negedge clk)
    begin
        if (rst)
        begin
            lastInstr  = '0;
            waitCycles = 0;
        end
        else if (psel && penable && !pready)
            waitCycles++;
        else if (psel && penable)
            checkTransfer();
    end

endmodule

// File: dv/decodeTb.sv
`timescale 1ns/1ps

module decodeTb;

    localparam logic [15:0] LfsrSeed      = 16'd17;
    localparam logic [15:0] LfsrTaps      = 16'hB400;
    localparam int          TimeoutCycles = 8;

    logic                              clk;
    logic                              rst;
    logic                              psel;
    logic                              penable;
    logic                              pwrite;
    logic [rvDecodePkg::AddrWidth-1:0] paddr;
    logic [rvDecodePkg::XLEN-1:0]      pwdata;
    logic [rvDecodePkg::XLEN-1:0]      prdata;
    logic                              pready;
    logic                              pslverr;
    logic [15:0]                       lfsr;
    int                                passCount;
    int                                failCount;
    int                                errorsAtStart;

    rvDecodeApb UUT
    (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    decodeMonitor mon
    (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ LfsrTaps) : (s >> 1);
    endfunction

    task automatic randBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsrNext(lfsr);
        end
    endtask

    function automatic logic [31:0] mkInstr(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [2:0] f3, input logic [6:0] op);
        return {f7, rs2, 5'd2, f3, 5'd1, op};   // rs1 = x2, rd = x1
    endfunction

    function automatic logic [6:0] validOpcode(input int k);
        case (k)
            0:       return rvDecodePkg::OpLui;
            1:       return rvDecodePkg::OpAuipc;
            2:       return rvDecodePkg::OpJal;
            3:       return rvDecodePkg::OpJalr;
            4:       return rvDecodePkg::OpBranch;
            5:       return rvDecodePkg::OpLoad;
            6:       return rvDecodePkg::OpStore;
            7:       return rvDecodePkg::OpAlu;
            default: return rvDecodePkg::OpAluImm;
        endcase
    endfunction

    // Starts and ends 2 ns after a rising edge
    task automatic apbTransfer(input logic wr, input logic [rvDecodePkg::AddrWidth-1:0] addr,
                               input logic [rvDecodePkg::XLEN-1:0] wdata);
        bit done;
        int waits;
        done    = 1'b0;
        waits   = 0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #2;
        penable = 1'b1;
        while (!done && (waits < TimeoutCycles))
        begin
            @(negedge clk);
            if (pready)
                done = 1'b1;
            else
                waits++;
            @(posedge clk);
            #2;
        end
        if (!done)
        begin
            $display("Timeout: pready never rose for access to address %h", addr);
            $display("=== FAIL ===");
            $finish;
        end
        else
        begin
            psel    = 1'b0;
            penable = 1'b0;
        end
    endtask

    task automatic apbWrite(input logic [rvDecodePkg::AddrWidth-1:0] addr,
                            input logic [rvDecodePkg::XLEN-1:0] data);
        apbTransfer(1'b1, addr, data);
    endtask

    task automatic apbRead(input logic [rvDecodePkg::AddrWidth-1:0] addr);
        apbTransfer(1'b0, addr, '0);
    endtask

    task automatic decodeCheck(input logic [rvDecodePkg::XLEN-1:0] word);
        apbWrite(rvDecodePkg::AddrInstr, word);
        apbRead(rvDecodePkg::AddrCtrl);
        apbRead(rvDecodePkg::AddrImm);
    endtask

    function automatic int errorsSoFar();
        return mon.errorCount + UUT.apbChk.assertFails;
    endfunction

    task automatic startTest(input string name);
        mon.testName  = name;
        errorsAtStart = errorsSoFar();
    endtask

    task automatic endTest();
        int errs;
        errs = errorsSoFar() - errorsAtStart;
        if (errs == 0)
        begin
            passCount++;
            $display("%s: ok", mon.testName);
        end
        else
        begin
            failCount++;
            $display("%s: failed with %0d errors", mon.testName, errs);
        end
    endtask

    task automatic runDirected();
        decodeCheck(mkInstr(7'h7a, 5'h13, 3'h5, rvDecodePkg::OpLui));
        decodeCheck(mkInstr(7'h12, 5'h04, 3'h1, rvDecodePkg::OpAuipc));
        decodeCheck(mkInstr(7'h40, 5'h1f, 3'h7, rvDecodePkg::OpJal));
        decodeCheck(mkInstr(7'h7f, 5'h10, 3'h0, rvDecodePkg::OpJalr));
        decodeCheck(mkInstr(7'h00, 5'h00, 3'h2, rvDecodePkg::OpJalr));   // Bad funct3
        for (int f = 0; f < 8; f++)
        begin
            decodeCheck(mkInstr(7'h6b, 5'h0e, f[2:0], rvDecodePkg::OpBranch));
            decodeCheck(mkInstr(7'h15, 5'h1c, f[2:0], rvDecodePkg::OpLoad));
            decodeCheck(mkInstr(7'h73, 5'h05, f[2:0], rvDecodePkg::OpStore));
            decodeCheck(mkInstr(rvDecodePkg::F7Base, 5'h03, f[2:0], rvDecodePkg::OpAlu));
            decodeCheck(mkInstr(7'h4c, 5'h11, f[2:0], rvDecodePkg::OpAluImm));
        end
        decodeCheck(mkInstr(rvDecodePkg::F7Alt, 5'h03, rvDecodePkg::AluAdd, rvDecodePkg::OpAlu));
        decodeCheck(mkInstr(rvDecodePkg::F7Alt, 5'h03, rvDecodePkg::AluShr, rvDecodePkg::OpAlu));
        decodeCheck(mkInstr(rvDecodePkg::F7Alt, 5'h03, rvDecodePkg::AluSll, rvDecodePkg::OpAlu));
        decodeCheck(mkInstr(rvDecodePkg::F7Base, 5'h1f, rvDecodePkg::AluSll, rvDecodePkg::OpAluImm));
        decodeCheck(mkInstr(rvDecodePkg::F7Base, 5'h07, rvDecodePkg::AluShr, rvDecodePkg::OpAluImm));
        decodeCheck(mkInstr(rvDecodePkg::F7Alt, 5'h09, rvDecodePkg::AluShr, rvDecodePkg::OpAluImm));
        decodeCheck(mkInstr(rvDecodePkg::F7Alt, 5'h09, rvDecodePkg::AluSll, rvDecodePkg::OpAluImm));
        decodeCheck(mkInstr(7'h00, 5'h00, 3'h0, 7'h7f));   // Unknown opcode
    endtask

    initial
    begin
        logic [31:0] word;
        logic [31:0] pick;
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        lfsr      = LfsrSeed;
        passCount = 0;
        failCount = 0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        startTest("reset state");
        apbRead(rvDecodePkg::AddrInstr);
        apbRead(rvDecodePkg::AddrCtrl);
        apbRead(rvDecodePkg::AddrImm);
        endTest();

        startTest("directed table");
        runDirected();
        endTest();

        startTest("random instructions");
        for (int i = 0; i < 200; i++)
        begin
            randBits(32, word);
            if (i % 2 == 0)
            begin
                randBits(4, pick);
                word[6:0] = validOpcode(pick % 9);
            end
            apbWrite(rvDecodePkg::AddrInstr, word);
            apbRead(rvDecodePkg::AddrInstr);
            apbRead(rvDecodePkg::AddrCtrl);
            apbRead(rvDecodePkg::AddrImm);
        end
        endTest();

        startTest("stale read");
        apbWrite(rvDecodePkg::AddrInstr, mkInstr(7'h01, 5'h02, rvDecodePkg::F3Half,
                                                 rvDecodePkg::OpLoad));
        apbRead(rvDecodePkg::AddrCtrl);
        apbWrite(rvDecodePkg::AddrInstr, mkInstr(rvDecodePkg::F7Alt, 5'h0a, rvDecodePkg::AluShr,
                                                 rvDecodePkg::OpAluImm));
        apbRead(rvDecodePkg::AddrCtrl);
        apbRead(rvDecodePkg::AddrImm);
        endTest();

        startTest("error responses");
        apbWrite(rvDecodePkg::AddrInstr, mkInstr(7'h2a, 5'h15, rvDecodePkg::F3Word,
                                                 rvDecodePkg::OpStore));
        apbRead(4'hc);   // Unmapped
        apbWrite(rvDecodePkg::AddrCtrl, 32'hffff_ffff);
        apbWrite(4'h6, 32'h1234_5678);
        apbRead(rvDecodePkg::AddrInstr);
        apbRead(rvDecodePkg::AddrCtrl);
        apbRead(rvDecodePkg::AddrImm);
        endTest();

        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: all.f
src/rvDecodePkg.sv
src/opDecoder.sv
src/immGen.sv
src/apbRegBlock.sv
src/rvDecodeApb.sv
dv/decodeApb_checker.sv
dv/decodeMonitor.sv
dv/decodeTb.sv
